// File: otp_config.svh
/*
 * OTP emulation sizes
 * Word, ECC, depth and command interface widths shared by all blocks
 */
`ifndef OTP_CONFIG_SVH
`define OTP_CONFIG_SVH

// Native data word
`define OTP_WIDTH 16
// Hamming check bits plus overall parity
`define OTP_ECC_WIDTH 6

// Array depth in native words
`define OTP_DEPTH 64
`define OTP_ADDR_WIDTH 6

// Size field holds words minus one, four words max
`define OTP_SIZE_WIDTH 2
`define OTP_IF_WIDTH 64

`endif

// File: otp_cmd_pkg.sv
/*
 * OTP command port types
 * Opcodes and response error codes of the ready/valid command port
 */
package otp_cmd_pkg;

  // Command opcodes
  typedef enum logic [2:0] {
    Read     = 3'b000,
    Write    = 3'b001,
    ReadRaw  = 3'b010,
    WriteRaw = 3'b011,
    Init     = 3'b111
  } cmd_e;

  // Response error codes
  // Code 1 stays free, no generic macro error here
  typedef enum logic [2:0] {
    NoError              = 3'h0,
    MacroEccCorrError    = 3'h2,
    MacroEccUncorrError  = 3'h3,
    MacroWriteBlankError = 3'h4
  } err_e;

endpackage

// File: otp_store_pkg.sv
/*
 * OTP storage types
 * Native data word, stored Hamming (22,16) code word and ECC status
 */
`include "otp_config.svh"

package otp_store_pkg;

  // Hamming check bits, without the overall parity
  localparam int CheckWidth = `OTP_ECC_WIDTH - 1;

  typedef logic [`OTP_WIDTH-1:0] data_word_t;

  // Bit 21 parity, bits 20..16 check c4..c0, bits 15..0 data
  typedef logic [`OTP_WIDTH+`OTP_ECC_WIDTH-1:0] code_word_t;

  // ECC status flags
  typedef logic [1:0] ecc_err_t;
  localparam int EccCorrBit   = 0;
  localparam int EccUncorrBit = 1;

  // Data bits feeding each check bit
  // Data bit i sits at the i-th non power of two position 3, 5, 6, 7, 9 ...
  localparam logic [CheckWidth-1:0][`OTP_WIDTH-1:0] EccMask = {
    16'hF800, 16'h07F0, 16'hC78E, 16'h366D, 16'hAD5B
  };

endpackage

// File: otp_secded_enc.sv
/*
 * Hamming (22,16) SECDED encoder
 * Builds five check bits and overall parity for one data word
 */
`timescale 1ns/1ns

module otp_secded_enc (
  input  otp_store_pkg::data_word_t data_i,
  output otp_store_pkg::code_word_t code_o
);
  import otp_store_pkg::*;

  logic [CheckWidth-1:0] check;
  logic                  parity;

  // Check bit j covers data bits whose position has bit j set
  always_comb begin
    for (int j = 0; j < CheckWidth; j++) begin
      check[j] = ^(data_i & EccMask[j]);
    end
  end

  // Even parity over all other 21 bits
  assign parity = ^{check, data_i};

  // Parity on top, then c4..c0, then data
  assign code_o = {parity, check, data_i};

endmodule

// File: otp_secded_dec.sv
/*
 * Hamming (22,16) SECDED decoder
 * Syndrome and parity check, single data bit correction, error flags
 * Raw word and valid travel alongside the result
 */
`timescale 1ns/1ns
`include "otp_config.svh"

module otp_secded_dec (
  input  otp_store_pkg::code_word_t code_i,
  input  logic                      valid_i,
  output otp_store_pkg::data_word_t data_o,
  output otp_store_pkg::ecc_err_t   err_o,
  output otp_store_pkg::code_word_t raw_o,
  output logic                      valid_o
);
  import otp_store_pkg::*;

  localparam int W = `OTP_WIDTH;

  logic [CheckWidth-1:0] syndrome;
  logic                  parity_err;
  data_word_t            flip;

  // Stored check bits against recomputed ones
  always_comb begin
    for (int j = 0; j < CheckWidth; j++) begin
      syndrome[j] = code_i[W+j] ^ (^(code_i[W-1:0] & EccMask[j]));
    end
  end

  // Whole word XORs to zero when parity holds
  assign parity_err = ^code_i;

  // Flip the data bit the syndrome points at
  // Syndromes naming a check or parity bit leave data alone
  always_comb begin
    logic [CheckWidth-1:0] pos;
    for (int i = 0; i < W; i++) begin
      // Codeword position of data bit i, read back from the masks
      for (int j = 0; j < CheckWidth; j++) begin
        pos[j] = EccMask[j][i];
      end
      flip[i] = parity_err && (syndrome == pos);
    end
  end

  assign data_o = code_i[W-1:0] ^ flip;

  // Parity mismatch means one flipped bit, even a zero syndrome
  // Nonzero syndrome with good parity means two
  assign err_o[EccCorrBit]   = parity_err;
  assign err_o[EccUncorrBit] = (syndrome != '0) && !parity_err;

  // Pass through beside the decoded data
  assign raw_o   = code_i;
  assign valid_o = valid_i;

endmodule

// File: otp_array.sv
/*
 * OTP backing RAM
 * Code word storage cleared to blank at reset
 * Registered read with a one-cycle read-valid strobe
 */
`timescale 1ns/1ns
`include "otp_config.svh"

module otp_array (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [`OTP_ADDR_WIDTH-1:0] addr_i,
  input  otp_store_pkg::code_word_t  wdata_i,
  output otp_store_pkg::code_word_t  rdata_o,
  output logic                       rvalid_o
);
  import otp_store_pkg::*;

  code_word_t mem_q [`OTP_DEPTH];
  code_word_t rdata_q;
  logic       rvalid_q;

  // Storage and strobe
  // Blank OTP reads as all zeros
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `OTP_DEPTH; i++) begin
        mem_q[i] <= '0;
      end
      rvalid_q <= 1'b0;
    end else begin
      // Only reads answer
      rvalid_q <= req_i && !we_i;
      if (req_i && we_i) begin
        mem_q[addr_i] <= wdata_i;
      end
    end
  end

  // Read register
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;

  // Every request names a known word and a clear direction
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> !$isunknown({we_i, addr_i}))
    else $error("OTP array request with unknown address or direction");

endmodule

// File: otp_ctrl_fsm.sv
/*
 * OTP command controller
 * Ready/valid command intake, per word read and read-modify-write
 * sequencing, blank check, ECC error reporting and fatal alert
 */
`timescale 1ns/1ns
`include "otp_config.svh"

module otp_ctrl_fsm (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Command port
  output logic                       ready_o,
  input  logic                       valid_i,
  input  otp_cmd_pkg::cmd_e          cmd_i,
  input  logic [`OTP_SIZE_WIDTH-1:0] size_i,
  input  logic [`OTP_ADDR_WIDTH-1:0] addr_i,
  input  logic [`OTP_IF_WIDTH-1:0]   wdata_i,
  // Response
  output logic                       valid_o,
  output logic [`OTP_IF_WIDTH-1:0]   rdata_o,
  output otp_cmd_pkg::err_e          err_o,
  output logic                       fatal_alert_o,
  // Array request
  output logic                       mem_req_o,
  output logic                       mem_we_o,
  output logic [`OTP_ADDR_WIDTH-1:0] mem_addr_o,
  output otp_store_pkg::code_word_t  mem_wdata_o,
  // Decoded read return
  input  logic                       rd_valid_i,
  input  otp_store_pkg::code_word_t  rd_code_i,
  input  otp_store_pkg::data_word_t  rd_data_i,
  input  otp_store_pkg::ecc_err_t    rd_err_i
);
  import otp_cmd_pkg::*;
  import otp_store_pkg::*;

  localparam int W        = `OTP_WIDTH;
  localparam int AW       = `OTP_ADDR_WIDTH;
  localparam int SW       = `OTP_SIZE_WIDTH;
  localparam int NumWords = 2 ** SW;

  typedef enum logic [3:0] {
    ResetSt, InitSt, IdleSt, ReadSt, ReadWaitSt,
    WriteCheckSt, WriteWaitSt, WriteSt, ErrorSt
  } state_e;

  state_e                         state_d, state_q;
  err_e                           acc_d, acc_q, err_q;
  logic                           ecc_d, ecc_q;
  logic                           valid_q;
  logic                           req, wren, cap, finish, accept;
  logic                           cnt_clr, cnt_en;
  logic [SW-1:0]                  cnt_q, size_q;
  logic [AW-1:0]                  addr_q;
  data_word_t [NumWords-1:0]      wdata_q, rdata_q;
  code_word_t [NumWords-1:0]      buf_d, buf_q;
  code_word_t                     cap_word, enc_word, new_word;
  logic                           blank_err;

  assign accept = ready_o && valid_i;

  ////////////////////////////////////////////////////////////
  // Command FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    acc_d   = acc_q;
    ecc_d   = ecc_q;
    ready_o = 1'b0;
    req     = 1'b0;
    wren    = 1'b0;
    cap     = 1'b0;
    finish  = 1'b0;
    cnt_clr = 1'b0;
    cnt_en  = 1'b0;
    unique case (state_q)
      // Other opcodes are taken and dropped here
      ResetSt: begin
        ready_o = 1'b1;
        if (valid_i && cmd_i == Init) begin
          state_d = InitSt;
        end
      end
      InitSt: begin
        acc_d   = NoError;
        finish  = 1'b1;
        state_d = IdleSt;
      end
      IdleSt: begin
        ready_o = 1'b1;
        cnt_clr = 1'b1;
        acc_d   = NoError;
        if (valid_i) begin
          unique case (cmd_i)
            Read: begin
              state_d = ReadSt;
              ecc_d   = 1'b1;
            end
            ReadRaw: begin
              state_d = ReadSt;
              ecc_d   = 1'b0;
            end
            Write: begin
              state_d = WriteCheckSt;
              ecc_d   = 1'b1;
            end
            WriteRaw: begin
              state_d = WriteCheckSt;
              ecc_d   = 1'b0;
            end
            default: ;
          endcase
        end
      end
      // Issue one word read
      ReadSt: begin
        req     = 1'b1;
        state_d = ReadWaitSt;
      end
      ReadWaitSt: begin
        if (rd_valid_i) begin
          cnt_en = 1'b1;
          if (ecc_q && rd_err_i[EccUncorrBit]) begin
            // Bail out, failing word not captured
            acc_d   = MacroEccUncorrError;
            finish  = 1'b1;
            state_d = IdleSt;
          end else begin
            cap = 1'b1;
            if (ecc_q && rd_err_i[EccCorrBit]) begin
              acc_d = MacroEccCorrError;
            end
            if (cnt_q == size_q) begin
              finish  = 1'b1;
              state_d = IdleSt;
            end else begin
              state_d = ReadSt;
            end
          end
        end
      end
      // Raw readout of every target word before any write
      WriteCheckSt: begin
        req     = 1'b1;
        state_d = WriteWaitSt;
      end
      WriteWaitSt: begin
        if (rd_valid_i) begin
          cap = 1'b1;
          if (cnt_q == size_q) begin
            cnt_clr = 1'b1;
            state_d = WriteSt;
          end else begin
            cnt_en  = 1'b1;
            state_d = WriteCheckSt;
          end
        end
      end
      // One OR-write per cycle
      WriteSt: begin
        req    = 1'b1;
        wren   = 1'b1;
        cnt_en = 1'b1;
        if (blank_err) begin
          acc_d = MacroWriteBlankError;
        end
        if (cnt_q == size_q) begin
          finish  = 1'b1;
          state_d = IdleSt;
        end
      end
      // Terminal, alert stays up
      ErrorSt: ;
      default: state_d = ErrorSt;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  // Read keeps the corrected data, write check keeps the raw word
  assign cap_word = (state_q == ReadWaitSt && ecc_q) ?
                    {rd_code_i[W+`OTP_ECC_WIDTH-1:W], rd_data_i} : rd_code_i;

  // Working buffer starts from the last response
  always_comb begin
    buf_d = buf_q;
    if (accept) begin
      for (int k = 0; k < NumWords; k++) begin
        buf_d[k] = {{`OTP_ECC_WIDTH{1'b0}}, rdata_q[k]};
      end
    end
    if (cap) begin
      buf_d[cnt_q] = cap_word;
    end
  end

  otp_secded_enc u_enc (
    .data_i (wdata_q[cnt_q]),
    .code_o (enc_word)
  );

  // Raw writes carry zero check bits
  assign new_word  = ecc_q ? enc_word : {{`OTP_ECC_WIDTH{1'b0}}, wdata_q[cnt_q]};
  // Programmed bit missing from the new word
  assign blank_err = |(buf_q[cnt_q] & ~new_word);

  assign mem_req_o   = req;
  assign mem_we_o    = wren;
  assign mem_addr_o  = addr_q + AW'(cnt_q);
  assign mem_wdata_o = buf_q[cnt_q] | new_word;

  assign valid_o       = valid_q;
  assign rdata_o       = rdata_q;
  assign err_o         = err_q;
  assign fatal_alert_o = (state_q == ErrorSt);

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ResetSt;
      acc_q   <= NoError;
      err_q   <= NoError;
      ecc_q   <= 1'b0;
      valid_q <= 1'b0;
      cnt_q   <= '0;
      rdata_q <= '0;
    end else begin
      state_q <= state_d;
      acc_q   <= acc_d;
      ecc_q   <= ecc_d;
      valid_q <= finish;
      if (cnt_clr) begin
        cnt_q <= '0;
      end else if (cnt_en) begin
        cnt_q <= cnt_q + 1'b1;
      end
      // Response only moves when a command ends
      if (finish) begin
        err_q <= acc_d;
      end
      if (finish && state_q == ReadWaitSt) begin
        for (int k = 0; k < NumWords; k++) begin
          rdata_q[k] <= buf_d[k][W-1:0];
        end
      end
    end
  end

  // Command payload and word buffer
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= addr_i;
      size_q  <= size_i;
      wdata_q <= wdata_i;
    end
    buf_q <= buf_d;
  end

  // Caller only sends Init before the macro is up
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == ResetSt && accept) |-> (cmd_i == Init))
    else $error("Non-Init command before initialization");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q != ResetSt && accept) |-> (cmd_i inside {Read, ReadRaw, Write, WriteRaw}))
    else $error("Illegal command after initialization");

  // Multi-word access never wraps past the top address
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o |-> (mem_addr_o >= addr_q))
    else $error("OTP address wrapped");

endmodule

// File: otp_macro_top.sv
/*
 * OTP macro emulation top
 * Controller issue, array read register, SECDED decode, controller capture
 */
`timescale 1ns/1ns
`include "otp_config.svh"

module otp_macro_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  output logic                       ready_o,
  input  logic                       valid_i,
  input  otp_cmd_pkg::cmd_e          cmd_i,
  input  logic [`OTP_SIZE_WIDTH-1:0] size_i,
  input  logic [`OTP_ADDR_WIDTH-1:0] addr_i,
  input  logic [`OTP_IF_WIDTH-1:0]   wdata_i,
  output logic                       valid_o,
  output logic [`OTP_IF_WIDTH-1:0]   rdata_o,
  output otp_cmd_pkg::err_e          err_o,
  output logic                       fatal_alert_o
);
  import otp_store_pkg::*;

  // Controller to array
  logic                       mem_req;
  logic                       mem_we;
  logic [`OTP_ADDR_WIDTH-1:0] mem_addr;
  code_word_t                 mem_wdata;

  // Array to decoder
  code_word_t rd_code;
  logic       rd_valid;

  // Decoder back to controller
  code_word_t dec_raw;
  data_word_t dec_data;
  ecc_err_t   dec_err;
  logic       dec_valid;

  otp_ctrl_fsm u_ctrl (
    .clk_i,
    .rst_ni,
    .ready_o,
    .valid_i,
    .cmd_i,
    .size_i,
    .addr_i,
    .wdata_i,
    .valid_o,
    .rdata_o,
    .err_o,
    .fatal_alert_o,
    .mem_req_o   (mem_req),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .rd_valid_i  (dec_valid),
    .rd_code_i   (dec_raw),
    .rd_data_i   (dec_data),
    .rd_err_i    (dec_err)
  );

  otp_array u_array (
    .clk_i,
    .rst_ni,
    .req_i    (mem_req),
    .we_i     (mem_we),
    .addr_i   (mem_addr),
    .wdata_i  (mem_wdata),
    .rdata_o  (rd_code),
    .rvalid_o (rd_valid)
  );

  // Decode sits combinationally behind the read register
  otp_secded_dec u_dec (
    .code_i  (rd_code),
    .valid_i (rd_valid),
    .data_o  (dec_data),
    .err_o   (dec_err),
    .raw_o   (dec_raw),
    .valid_o (dec_valid)
  );

endmodule

// File: tb_otp_macro.sv
/*
 * OTP macro emulation testbench
 * Reference ECC model, random write/read traffic, blank and ECC error cases
 */
`timescale 1ns/1ns
`include "otp_config.svh"

module tb_otp_macro;
  import otp_cmd_pkg::*;
  import otp_store_pkg::*;

  localparam int TimeoutCycles = 200;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       ready_o;
  logic                       valid_i;
  cmd_e                       cmd_i;
  logic [`OTP_SIZE_WIDTH-1:0] size_i;
  logic [`OTP_ADDR_WIDTH-1:0] addr_i;
  logic [`OTP_IF_WIDTH-1:0]   wdata_i;
  logic                       valid_o;
  logic [`OTP_IF_WIDTH-1:0]   rdata_o;
  err_e                       err_o;
  logic                       fatal_alert_o;

  // Reference state
  code_word_t                 ref_mem [`OTP_DEPTH];
  logic [`OTP_IF_WIDTH-1:0]   ref_rdata;

  // Expected responses, indexed by response count
  string                      name_q [$];
  logic [`OTP_IF_WIDTH-1:0]   exp_data_q [$];
  err_e                       exp_err_q [$];
  int                         resp_count;

  logic [`OTP_SIZE_WIDTH-1:0] size;
  logic [`OTP_ADDR_WIDTH-1:0] addr;
  data_word_t                 d;
  int                         b1;
  int                         b2;

  otp_macro_top u_otp_macro_top (
    .clk_i,
    .rst_ni,
    .ready_o,
    .valid_i,
    .cmd_i,
    .size_i,
    .addr_i,
    .wdata_i,
    .valid_o,
    .rdata_o,
    .err_o,
    .fatal_alert_o
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Position of data bit i, skipping powers of two
  function automatic int data_pos(int i);
    int n;
    n = 0;
    for (int p = 1; p < 22; p++) begin
      if ((p & (p - 1)) != 0) begin
        if (n == i) begin
          return p;
        end
        n++;
      end
    end
    return 0;
  endfunction

  // Check bits are the XOR of the positions of all set data bits
  function automatic code_word_t ref_encode(data_word_t data);
    logic [4:0] c;
    c = '0;
    for (int i = 0; i < `OTP_WIDTH; i++) begin
      if (data[i]) begin
        c ^= 5'(data_pos(i));
      end
    end
    return {^{c, data}, c, data};
  endfunction

  function automatic data_word_t ref_decode(input code_word_t code, output ecc_err_t err);
    code_word_t re;
    logic [4:0] syn;
    logic       par_err;
    data_word_t data;
    data    = code[`OTP_WIDTH-1:0];
    re      = ref_encode(data);
    syn     = code[20:16] ^ re[20:16];
    par_err = ^code;
    err     = {(syn != 5'd0) && !par_err, par_err};
    // Single error names its position
    if (par_err) begin
      for (int i = 0; i < `OTP_WIDTH; i++) begin
        if (syn == 5'(data_pos(i))) begin
          data[i] = ~data[i];
        end
      end
    end
    return data;
  endfunction

  // Updates model memory and response data, returns the expected error
  function automatic err_e ref_exec(cmd_e cmd, logic [1:0] sz, logic [5:0] a0,
                                    logic [`OTP_IF_WIDTH-1:0] wdata);
    err_e       err;
    logic       stop;
    logic [5:0] a;
    code_word_t old_w;
    code_word_t new_w;
    data_word_t w;
    data_word_t dec;
    ecc_err_t   e;
    err  = NoError;
    stop = 1'b0;
    for (int k = 0; k <= int'(sz); k++) begin
      a     = a0 + 6'(k);
      w     = wdata[16*k +: 16];
      old_w = ref_mem[a];
      case (cmd)
        Read: begin
          if (!stop) begin
            dec = ref_decode(old_w, e);
            if (e[1]) begin
              err  = MacroEccUncorrError;
              stop = 1'b1;
            end else begin
              if (e[0]) begin
                err = MacroEccCorrError;
              end
              ref_rdata[16*k +: 16] = dec;
            end
          end
        end
        ReadRaw: ref_rdata[16*k +: 16] = old_w[`OTP_WIDTH-1:0];
        Write, WriteRaw: begin
          new_w = (cmd == Write) ? ref_encode(w) : {{`OTP_ECC_WIDTH{1'b0}}, w};
          // Programmed bit the new word would clear
          if (|(old_w & ~new_w)) begin
            err = MacroWriteBlankError;
          end
          ref_mem[a] = old_w | new_w;
        end
        default: ;
      endcase
    end
    return err;
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Testbench failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_data(string name, logic [`OTP_IF_WIDTH-1:0] exp,
                            logic [`OTP_IF_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_err(string name, err_e exp, err_e act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %s, actual %s", name, exp.name(), act.name());
      abort_run();
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // Response compare, sampled mid-cycle
  always @(negedge clk_i) begin
    if (fatal_alert_o === 1'b1) begin
      $display("ERROR: fatal_alert_o went high");
      abort_run();
    end else if (valid_o === 1'b1) begin
      if (resp_count >= exp_err_q.size()) begin
        $display("ERROR: response pulse with no command pending");
        abort_run();
      end else begin
        check_data(name_q[resp_count], exp_data_q[resp_count], rdata_o);
        check_err(name_q[resp_count], exp_err_q[resp_count], err_o);
        resp_count++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic wait_ready();
    int n;
    n = 0;
    while (ready_o !== 1'b1 && n < TimeoutCycles) begin
      @(posedge clk_i);
      #1;
      n++;
    end
    if (ready_o !== 1'b1) begin
      $display("ERROR: ready_o stayed low for %0d cycles", TimeoutCycles);
      abort_run();
    end
  endtask

  // One command through the handshake, then wait for its response
  task automatic run_cmd(string name, cmd_e cmd, logic [1:0] sz, logic [5:0] a0,
                         logic [`OTP_IF_WIDTH-1:0] wdata);
    err_e exp_err;
    int   target;
    int   n;
    wait_ready();
    exp_err = ref_exec(cmd, sz, a0, wdata);
    name_q.push_back(name);
    exp_data_q.push_back(ref_rdata);
    exp_err_q.push_back(exp_err);
    target  = resp_count + 1;
    valid_i = 1'b1;
    cmd_i   = cmd;
    size_i  = sz;
    addr_i  = a0;
    wdata_i = wdata;
    @(posedge clk_i);
    #1;
    valid_i = 1'b0;
    n = 0;
    while (resp_count < target && n < TimeoutCycles) begin
      @(posedge clk_i);
      #1;
      n++;
    end
    if (resp_count < target) begin
      $display("ERROR: no response to %s within %0d cycles", name, TimeoutCycles);
      abort_run();
    end
  endtask

  initial begin
    void'($urandom(32'heab37a59));
    rst_ni     = 1'b0;
    valid_i    = 1'b0;
    cmd_i      = Read;
    size_i     = '0;
    addr_i     = '0;
    wdata_i    = '0;
    resp_count = 0;
    ref_rdata  = '0;
    for (int i = 0; i < `OTP_DEPTH; i++) begin
      ref_mem[i] = '0;
    end
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Idle outputs out of reset
    check_flag("reset_ready", 1'b1, ready_o);
    check_flag("reset_valid", 1'b0, valid_o);
    check_flag("reset_alert", 1'b0, fatal_alert_o);
    run_cmd("init", Init, 2'd0, 6'd0, '0);

    // Blank region reads back zero
    run_cmd("read_blank", Read, 2'd3, 6'd40, '0);

    // Random traffic, one fresh 4-word region each
    for (int t = 0; t < 10; t++) begin
      size = 2'($urandom % 4);
      addr = 6'(4 * t + ($urandom % (4 - size)));
      run_cmd("write_random", Write, size, addr, {$urandom, $urandom});
      run_cmd("read_random", Read, size, addr, '0);
      run_cmd("readraw_random", ReadRaw, size, addr, '0);
    end

    // Clearing a programmed bit
    run_cmd("write_first", Write, 2'd0, 6'd48, 64'h1234);
    run_cmd("write_blank", Write, 2'd0, 6'd48, 64'h4321);
    run_cmd("readraw_blank", ReadRaw, 2'd0, 6'd48, '0);

    // Single data bit overlay
    b1 = $urandom % 16;
    d  = 16'($urandom) & ~(16'h1 << b1);
    run_cmd("write_single", Write, 2'd0, 6'd52, 64'(d));
    run_cmd("overlay_single", WriteRaw, 2'd0, 6'd52, 64'(16'h1 << b1));
    run_cmd("read_corr", Read, 2'd0, 6'd52, '0);
    run_cmd("readraw_corr", ReadRaw, 2'd0, 6'd52, '0);

    // Two data bit overlay, read stops at the bad word
    b2 = (b1 + 1 + ($urandom % 15)) % 16;
    d  = 16'($urandom) & ~((16'h1 << b1) | (16'h1 << b2));
    run_cmd("write_double", Write, 2'd0, 6'd56, 64'(d));
    run_cmd("overlay_double", WriteRaw, 2'd0, 6'd56,
            64'((16'h1 << b1) | (16'h1 << b2)));
    run_cmd("read_uncorr", Read, 2'd2, 6'd55, '0);

    // Quiet tail, a stray pulse here still fails
    repeat (4) @(posedge clk_i);
    $display("Testbench passed");
    $finish;
  end

endmodule

// File: flist.f
+incdir+.
otp_cmd_pkg.sv
otp_store_pkg.sv
otp_secded_enc.sv
otp_secded_dec.sv
otp_array.sv
otp_ctrl_fsm.sv
otp_macro_top.sv
tb_otp_macro.sv

// File: Bender.yml
package:
  name: otp_macro

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - otp_cmd_pkg.sv
      - otp_store_pkg.sv
      - otp_secded_enc.sv
      - otp_secded_dec.sv
      - otp_array.sv
      - otp_ctrl_fsm.sv
      - otp_macro_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_otp_macro.sv
